// File: Makefile
# Verilator build for the receive channel alignment testbench

VERILATOR ?= verilator
TOP       ?= ca_rx_align_tb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= Something failed
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "Everything OK" $(LOG); then echo "Simulation did not finish"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: bench/ca_rx_align_props.sv
// Channel alignment assertions
// Bound to the top level, checks output valid, done and reset state
`timescale 1ns/100ps
`default_nettype none

`include "ca_align_macros.svh"

module ca_rx_align_props
  (
  input logic                     com_clk,
  input logic                     rst_com_n,
  input logic                     rx_dout_valid,
  input logic                     align_done,
  input logic                     align_err,
  input logic [`CA_NUM_LANES-1:0] fifo_empty
  );

  // Popped words need data in every lane
  valid_needs_data: assert property (@(posedge com_clk) disable iff (!rst_com_n)
    rx_dout_valid |-> ~|fifo_empty)
    else $error("output valid while a lane FIFO is empty");

  done_needs_data: assert property (@(posedge com_clk) disable iff (!rst_com_n)
    align_done |-> ~|fifo_empty)
    else $error("align_done while a lane FIFO is empty");

  // Nothing survives reset
  reset_clears: assert property (@(posedge com_clk)
    !rst_com_n |-> (!align_done && !align_err && !rx_dout_valid && (&fifo_empty)))
    else $error("status held during reset");

endmodule

bind ca_rx_align ca_rx_align_props u_props
  (
  .com_clk       (com_clk),
  .rst_com_n     (rst_com_n),
  .rx_dout_valid (rx_dout_valid),
  .align_done    (align_done),
  .align_err     (align_err),
  .fifo_empty    (fifo_empty)
  );

`default_nettype wire

// File: bench/ca_rx_align_tb.sv
// Channel alignment testbench
// Skewed lane streams, reference words and output comparison
`timescale 1ns/100ps
`default_nettype none

`include "ca_align_macros.svh"

module ca_rx_align_tb;

  import ca_align_pkg::*;

  localparam int TEST_CYCLES = 400;
  localparam int NUM_TESTS   = 6;
  localparam int MAX_CYCLES  = NUM_TESTS * TEST_CYCLES;
  localparam int NO_STOP     = 1 << 30;

  logic                           com_clk;
  logic                           rst_com_n;
  lane_data_t [`CA_NUM_LANES-1:0] rx_din = '0;
  stb_cfg_t                       stb_cfg;
  align_cfg_t                     align_cfg;
  lane_data_t [`CA_NUM_LANES-1:0] rx_dout;
  logic                           rx_dout_valid;
  logic                           align_done;
  logic                           align_err;
  logic                           stb_pos_err;
  logic                           stb_coding_err;
  logic [`CA_NUM_LANES-1:0]       fifo_full;
  logic [`CA_NUM_LANES-1:0]       fifo_empty;

  integer seed = 32'hc402_33d1;
  int     stb_pos = 43;             // Word 1, bit 3
  int     stb_period = 8;
  int     stop_seq = NO_STOP;       // Strobes missing from here
  int     resume_seq = NO_STOP;
  int     skew = 0;
  logic   stream_on;
  int     seq_cnt = 0;              // Lane 0 sequence number
  logic   chk_en;
  logic   gap_ok;
  int     start_seq;
  int     exp_seq = 0;
  int     valid_cnt = 0;
  int     cmp_errs = 0;
  int     done_cnt = 0;
  int     err_cnt = 0;
  logic   prev_valid = 1'b0;
  int     test_errs;
  int     tests_passed;
  int     tests_failed;
  int     cycles = 0;

  ca_rx_align dut
    (
    .com_clk        (com_clk),
    .rst_com_n      (rst_com_n),
    .rx_din         (rx_din),
    .stb_cfg        (stb_cfg),
    .align_cfg      (align_cfg),
    .rx_dout        (rx_dout),
    .rx_dout_valid  (rx_dout_valid),
    .align_done     (align_done),
    .align_err      (align_err),
    .stb_pos_err    (stb_pos_err),
    .stb_coding_err (stb_coding_err),
    .fifo_full      (fifo_full),
    .fifo_empty     (fifo_empty)
    );

  initial
  begin
    com_clk = 1'b0;
    forever #10 com_clk = ~com_clk;
  end

  // Expected word for a sequence number
  function automatic lane_data_t expected_word(int seq);
    integer      s;
    logic [95:0] r;
    lane_data_t  w;
    if (seq < 0)
      return '0;                    // Idle before a lagging lane starts
    s = seed ^ (seq * 32'h9e37_79b9);
    r = {$random(s), $random(s), $random(s)};
    w = r[`CA_LANE_BITS-1:0];
    w[stb_pos] = (seq % stb_period == 0) && !(seq >= stop_seq && seq < resume_seq);
    return w;
  endfunction

  //////////////////////////////////////////////////
  // Lane streams, lane 1 lags by skew

  always @(posedge com_clk)
  begin
    if (stream_on)
    begin
      rx_din[0] <= expected_word(seq_cnt);
      rx_din[1] <= expected_word(seq_cnt - skew);
      seq_cnt   <= seq_cnt + 1;
    end
    else
    begin
      rx_din  <= '0;
      seq_cnt <= 0;
    end
  end

  //////////////////////////////////////////////////
  // Output compare, sampled mid cycle

  always @(negedge com_clk)
  begin
    if (rst_com_n)
    begin
      if (align_done)
        done_cnt++;
      if (align_err)
        err_cnt++;
      if (chk_en && rx_dout_valid)
      begin
        if (!prev_valid)
          exp_seq = start_seq;      // Stream (re)starts at the strobe word
        for (int l = 0; l < `CA_NUM_LANES; l++)
        begin
          if (rx_dout[l] !== expected_word(exp_seq))
          begin
            $display("CHECK FAILED at %0t: lane %0d word %0d is %h, expected %h",
                     $time, l, exp_seq, rx_dout[l], expected_word(exp_seq));
            cmp_errs++;
          end
        end
        exp_seq++;
        valid_cnt++;
      end
      else if (chk_en && prev_valid && !gap_ok)
      begin
        $display("CHECK FAILED at %0t: output stream stopped after word %0d", $time, exp_seq);
        cmp_errs++;
      end
      prev_valid = rx_dout_valid;
    end
    else
      prev_valid = 1'b0;
  end

  // Run limit
  always @(posedge com_clk)
  begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES)
    begin
      $display("Timeout: the run went past %0d cycles", MAX_CYCLES);
      $display("Something failed");
      $finish;
    end
  end

  task automatic note_failure(input string msg);
    $display("%s (time %0t)", msg, $time);
    test_errs++;
  endtask

  // Reset, configure, go online, then start both streams
  task automatic start_test(input int t_skew, input int t_intv, input int t_dly,
                            input logic t_fly, input int t_stop, input int t_resume);
    @(posedge com_clk);
    stream_on  <= 1'b0;
    chk_en     = 1'b0;
    skew       = t_skew;
    stop_seq   = t_stop;
    resume_seq = t_resume;
    rst_com_n <= 1'b0;
    stb_cfg   <= {8'h02, 40'h1 << 3, 16'(t_intv)};
    align_cfg <= {1'b0, t_fly, 3'(t_dly)};
    repeat (2) @(posedge com_clk);
    rst_com_n <= 1'b1;
    @(posedge com_clk);
    align_cfg.online <= 1'b1;
    repeat (2) @(posedge com_clk);
    stream_on <= 1'b1;
  endtask

  // which 0 is align_done, 1 is align_err
  task automatic wait_for_level(input int which, input logic level, input int max_cyc,
                                output bit ok);
    ok = 1'b0;
    for (int i = 0; i < max_cyc; i++)
    begin
      @(negedge com_clk);
      if (((which == 0) ? align_done : align_err) == level)
      begin
        ok = 1'b1;
        break;
      end
    end
  endtask

  task automatic wait_seq(input int n);
    while (seq_cnt < n)
      @(negedge com_clk);
  endtask

  task automatic report_test(input string name, input int cmp0, input int test0);
    if (cmp_errs == cmp0 && test_errs == test0)
    begin
      tests_passed++;
      $display("Test %s: pass", name);
    end
    else
    begin
      tests_failed++;
      $display("Test %s: FAIL", name);
    end
  endtask

  // Straight deskew, with or without read delay
  task automatic deskew_test(input string name, input int dly);
    int cmp0;
    int test0;
    int err0;
    int v0;
    bit ok;
    cmp0  = cmp_errs;
    test0 = test_errs;
    start_test(5, 8, dly, 1'b0, NO_STOP, NO_STOP);
    start_seq = 0;
    gap_ok    = 1'b0;
    chk_en    = 1'b1;
    err0      = err_cnt;
    v0        = valid_cnt;
    wait_for_level(0, 1'b1, 100, ok);
    if (!ok)
      note_failure("align_done did not rise");
    // Occupancy is skew plus delay, well inside the depth
    if (fifo_full != '0 || fifo_empty != '0)
    begin
      $display("CHECK FAILED at %0t: FIFO flags full %b empty %b while aligned",
               $time, fifo_full, fifo_empty);
      test_errs++;
    end
    wait_seq(200);
    if (valid_cnt - v0 < 150)
      note_failure("too few aligned words came out");
    if (err_cnt != err0)
    begin
      $display("CHECK FAILED at %0t: align_err rose during a clean stream", $time);
      test_errs++;
    end
    chk_en = 1'b0;
    report_test(name, cmp0, test0);
  endtask

  initial
  begin
    int  cmp0;
    int  test0;
    int  d0;
    bit  ok;
    rst_com_n    = 1'b0;
    stream_on    = 1'b0;
    chk_en       = 1'b0;
    gap_ok       = 1'b0;
    start_seq    = 0;
    stb_cfg      = {8'h02, 40'h1 << 3, 16'd8};
    align_cfg    = '0;
    test_errs    = 0;
    tests_passed = 0;
    tests_failed = 0;

    deskew_test("1 deskew", 0);
    deskew_test("2 read delay", 5);

    // 3: strobes stop, fly low
    cmp0  = cmp_errs;
    test0 = test_errs;
    start_test(5, 8, 0, 1'b0, 40, NO_STOP);
    start_seq = 0;
    chk_en    = 1'b1;
    wait_for_level(0, 1'b1, 100, ok);
    if (!ok)
      note_failure("align_done did not rise before the strobes stopped");
    wait_seq(40);
    wait_for_level(1, 1'b1, 8 + 5 + 8, ok);
    if (!ok)
      note_failure("align_err did not rise after the strobes stopped");
    repeat (20)
    begin
      @(negedge com_clk);
      if (!align_err)
      begin
        $display("CHECK FAILED at %0t: align_err dropped after an interval error", $time);
        test_errs++;
      end
    end
    chk_en = 1'b0;
    report_test("3 interval error", cmp0, test0);

    // 4: strobes stop and resume, fly high
    cmp0  = cmp_errs;
    test0 = test_errs;
    start_test(5, 8, 0, 1'b1, 40, 120);
    start_seq = 0;
    gap_ok    = 1'b1;
    chk_en    = 1'b1;
    wait_for_level(0, 1'b1, 100, ok);
    if (!ok)
      note_failure("align_done did not rise before the strobes stopped");
    wait_for_level(1, 1'b1, 80, ok);
    if (!ok)
      note_failure("align_err did not pulse after the strobes stopped");
    start_seq = 120;                // Realigned stream begins here
    wait_for_level(1, 1'b0, 3, ok);
    if (!ok)
      note_failure("align_err stayed high in recovery mode");
    wait_for_level(0, 1'b0, 5, ok);
    if (!ok)
      note_failure("align_done stayed high through the soft reset");
    wait_for_level(0, 1'b1, 150, ok);
    if (!ok)
      note_failure("align_done did not rise again after realignment");
    wait_seq(200);
    if (exp_seq < 180)
      note_failure("no aligned data after realignment");
    chk_en = 1'b0;
    gap_ok = 1'b0;
    report_test("4 recovery", cmp0, test0);

    // 5: select checks are combinational
    cmp0  = cmp_errs;
    test0 = test_errs;
    @(posedge com_clk);
    stream_on <= 1'b0;
    stb_cfg   <= {8'h03, 40'h1 << 3, 16'd8};
    @(negedge com_clk);
    if (!stb_coding_err)
    begin
      $display("CHECK FAILED at %0t: two word select bits not flagged", $time);
      test_errs++;
    end
    @(posedge com_clk);
    stb_cfg <= {8'h04, 40'h1, 16'd8};
    @(negedge com_clk);
    if (!stb_pos_err || stb_coding_err)
    begin
      $display("CHECK FAILED at %0t: strobe at bit 80 not flagged as position error", $time);
      test_errs++;
    end
    @(posedge com_clk);
    stb_cfg <= {8'h02, 40'h1 << 3, 16'd8};
    @(negedge com_clk);
    if (stb_pos_err || stb_coding_err)
    begin
      $display("CHECK FAILED at %0t: valid selects still flagged", $time);
      test_errs++;
    end
    report_test("5 select checks", cmp0, test0);

    // 6: skew past the FIFO depth
    cmp0  = cmp_errs;
    test0 = test_errs;
    start_test(20, 8, 0, 1'b0, NO_STOP, NO_STOP);
    d0 = done_cnt;
    wait_for_level(1, 1'b1, 80, ok);
    if (!ok)
      note_failure("align_err did not rise on FIFO overflow");
    // Early lane fills up, late lane never saw its strobe
    if (!fifo_full[0] || fifo_full[1] || !fifo_empty[1])
    begin
      $display("CHECK FAILED at %0t: FIFO flags full %b empty %b after overflow",
               $time, fifo_full, fifo_empty);
      test_errs++;
    end
    repeat (60)
    begin
      @(negedge com_clk);
      if (!align_err)
      begin
        $display("CHECK FAILED at %0t: align_err dropped after overflow", $time);
        test_errs++;
      end
    end
    if (done_cnt != d0)
      note_failure("align_done rose although a lane overflowed");
    report_test("6 overflow", cmp0, test0);

    $display("Tests passed: %0d, failed: %0d", tests_passed, tests_failed);
    if (tests_failed == 0 && cmp_errs == 0 && test_errs == 0)
    begin
      $display("Everything OK");
    end
    else
    begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: design/ca_align_ctrl.sv
// Alignment controller with the FSM, read delay and common pop
// Also checks the strobe select configuration
`timescale 1ns/100ps
`default_nettype none

`include "ca_align_macros.svh"

module ca_align_ctrl
  (
  input  logic                                         com_clk,
  input  logic                                         rst_com_n,
  input  ca_align_pkg::align_cfg_t                     align_cfg,
  input  ca_align_pkg::stb_cfg_t                       stb_cfg,
  input  ca_align_pkg::lane_stat_t [`CA_NUM_LANES-1:0] lane_stat,
  output logic                                         det_en,
  output logic                                         fifo_pop,
  output logic                                         soft_reset,
  output logic                                         align_done,
  output logic                                         align_err,
  output logic                                         stb_pos_err,
  output logic                                         stb_coding_err
  );

  import ca_align_pkg::*;

  localparam int WD_CNT_BITS  = $clog2(`CA_SEL_WORDS + 1);
  localparam int BIT_CNT_BITS = $clog2(`CA_WORD_BITS + 1);
  localparam int WD_IDX_BITS  = $clog2(`CA_SEL_WORDS);
  localparam int BIT_IDX_BITS = $clog2(`CA_WORD_BITS);
  localparam int LOC_BITS     = $clog2(`CA_SEL_WORDS * `CA_WORD_BITS);

  align_state_e              state;
  align_state_e              next_state;
  logic                      online_q;
  logic [`CA_RDDLY_BITS-1:0] rd_dly;
  logic                      all_first;
  logic                      any_ovf;
  logic                      any_intv_err;
  logic [WD_CNT_BITS-1:0]    wd_ones;
  logic [BIT_CNT_BITS-1:0]   bit_ones;
  logic [WD_IDX_BITS-1:0]    wd_idx;
  logic [BIT_IDX_BITS-1:0]   bit_idx;
  logic [LOC_BITS-1:0]       stb_loc;

  // Lane status reduction
  always_comb
  begin
    all_first    = 1'b1;
    any_ovf      = 1'b0;
    any_intv_err = 1'b0;
    for (int i = 0; i < `CA_NUM_LANES; i++)
    begin
      all_first    = all_first & lane_stat[i].first_stb;
      any_ovf      = any_ovf | lane_stat[i].overflow;
      any_intv_err = any_intv_err | lane_stat[i].intv_err;
    end
  end

  //////////////////////////////////////////////////
  // Read delay and pop

  always_ff @(posedge com_clk or negedge rst_com_n)
  begin
    if (!rst_com_n)
    begin
      online_q <= 1'b0;
      rd_dly   <= '0;
    end
    else
    begin
      online_q <= align_cfg.online;
      if (align_cfg.online & ~online_q)
        rd_dly <= align_cfg.rden_dly;   // Load on online edge
      else if (all_first & (|rd_dly))
        rd_dly <= rd_dly - 1'b1;
    end
  end

  assign fifo_pop = all_first & (rd_dly == '0);

  //////////////////////////////////////////////////
  // Alignment FSM

  always_comb
  begin
    next_state = state;
    case (state)
      st_idle:
        if (align_cfg.online)
          next_state = st_online;
      st_online:
        if (any_ovf)
          next_state = align_cfg.fly ? st_soft_reset : st_err;
        else if (all_first)
          next_state = st_aligned;
      st_aligned:
        if (rd_dly == '0)
          next_state = st_done;
      st_err:
        if (align_cfg.fly)
          next_state = st_soft_reset;
      st_done:
        if (any_intv_err & align_cfg.fly)
          next_state = st_soft_reset;
      st_soft_reset:
        next_state = st_online;         // Single cycle
      default:
        next_state = st_idle;
    endcase
  end

  always_ff @(posedge com_clk or negedge rst_com_n)
  begin
    if (!rst_com_n)
    begin
      state      <= st_idle;
      align_done <= 1'b0;
      align_err  <= 1'b0;
    end
    else
    begin
      state      <= next_state;
      align_done <= (state == st_done);
      align_err  <= (state == st_err) | ((state == st_done) & any_intv_err);
    end
  end

  assign det_en     = (state == st_online) | (state == st_aligned) | (state == st_done);
  assign soft_reset = (state == st_soft_reset);

  //////////////////////////////////////////////////
  // Strobe select checks

  always_comb
  begin
    wd_ones  = '0;
    bit_ones = '0;
    wd_idx   = '0;
    bit_idx  = '0;
    for (int i = `CA_SEL_WORDS - 1; i >= 0; i--)
    begin
      wd_ones = wd_ones + WD_CNT_BITS'(stb_cfg.wd_sel[i]);
      if (stb_cfg.wd_sel[i])
        wd_idx = WD_IDX_BITS'(i);       // Lowest set bit wins
    end
    for (int i = `CA_WORD_BITS - 1; i >= 0; i--)
    begin
      bit_ones = bit_ones + BIT_CNT_BITS'(stb_cfg.bit_sel[i]);
      if (stb_cfg.bit_sel[i])
        bit_idx = BIT_IDX_BITS'(i);
    end
  end

  assign stb_loc = LOC_BITS'(wd_idx) * LOC_BITS'(`CA_WORD_BITS) + LOC_BITS'(bit_idx);

  assign stb_coding_err = (wd_ones != WD_CNT_BITS'(1)) | (bit_ones != BIT_CNT_BITS'(1));
  assign stb_pos_err    = (stb_loc >= LOC_BITS'(`CA_LANE_BITS));

endmodule

`default_nettype wire

// File: design/ca_align_macros.svh
// Channel alignment constants
// Lane geometry, strobe select widths and FIFO depth
`ifndef CA_ALIGN_MACROS_SVH
`define CA_ALIGN_MACROS_SVH

// Lane count and width
`define CA_NUM_LANES   2
`define CA_LANE_BITS   80

// Strobe position select, 8 words of 40 bits
`define CA_SEL_WORDS   8
`define CA_WORD_BITS   40

`define CA_FIFO_AW     4   // 16 entries
`define CA_INTV_BITS   16  // Strobe interval counter
`define CA_RDDLY_BITS  3   // Read delay after alignment

`endif

// File: design/ca_align_pkg.sv
// Channel alignment types
// Configuration, per-lane status and alignment FSM states
`default_nettype none

`include "ca_align_macros.svh"

package ca_align_pkg;

  typedef logic [`CA_LANE_BITS-1:0] lane_data_t;

  // Strobe location and expected spacing
  typedef struct packed {
    logic [`CA_SEL_WORDS-1:0]  wd_sel;   // One-hot word select
    logic [`CA_WORD_BITS-1:0]  bit_sel;  // One-hot bit within word
    logic [`CA_INTV_BITS-1:0]  intv;     // Cycles between strobes
  } stb_cfg_t;

  typedef struct packed {
    logic                      online;
    logic                      fly;      // Realign on error
    logic [`CA_RDDLY_BITS-1:0] rden_dly;
  } align_cfg_t;

  // Lane status seen by the controller
  typedef struct packed {
    logic first_stb;
    logic overflow;   // One-cycle pulse
    logic intv_err;   // Sticky until soft reset
    logic full;
    logic empty;
  } lane_stat_t;

  typedef enum logic [2:0] {
    st_idle       = 3'd0,
    st_online     = 3'd1,
    st_aligned    = 3'd2,
    st_err        = 3'd3,
    st_done       = 3'd4,
    st_soft_reset = 3'd5
  } align_state_e;

endpackage

`default_nettype wire

// File: design/ca_rx_align.sv
// Receive channel alignment top
// Two deskew lanes and the alignment controller on com_clk
`timescale 1ns/100ps
`default_nettype none

`include "ca_align_macros.svh"

module ca_rx_align
  (
  input  logic                                         com_clk,
  input  logic                                         rst_com_n,
  input  ca_align_pkg::lane_data_t [`CA_NUM_LANES-1:0] rx_din,
  input  ca_align_pkg::stb_cfg_t                       stb_cfg,
  input  ca_align_pkg::align_cfg_t                     align_cfg,
  output ca_align_pkg::lane_data_t [`CA_NUM_LANES-1:0] rx_dout,
  output logic                                         rx_dout_valid,
  output logic                                         align_done,
  output logic                                         align_err,
  output logic                                         stb_pos_err,
  output logic                                         stb_coding_err,
  output logic [`CA_NUM_LANES-1:0]                     fifo_full,
  output logic [`CA_NUM_LANES-1:0]                     fifo_empty
  );

  import ca_align_pkg::*;

  lane_stat_t [`CA_NUM_LANES-1:0] lane_stat;
  logic                           det_en;
  logic                           fifo_pop;   // Common to all lanes
  logic                           soft_reset;

  generate
    for (genvar g = 0; g < `CA_NUM_LANES; g++)
    begin : g_lane
      ca_rx_lane u_lane
        (
        .com_clk    (com_clk),
        .rst_com_n  (rst_com_n),
        .din        (rx_din[g]),
        .stb_cfg    (stb_cfg),
        .det_en     (det_en),
        .fifo_pop   (fifo_pop),
        .soft_reset (soft_reset),
        .dout       (rx_dout[g]),
        .stat       (lane_stat[g])
        );

      assign fifo_full[g]  = lane_stat[g].full;
      assign fifo_empty[g] = lane_stat[g].empty;
    end
  endgenerate

  ca_align_ctrl u_ctrl
    (
    .com_clk        (com_clk),
    .rst_com_n      (rst_com_n),
    .align_cfg      (align_cfg),
    .stb_cfg        (stb_cfg),
    .lane_stat      (lane_stat),
    .det_en         (det_en),
    .fifo_pop       (fifo_pop),
    .soft_reset     (soft_reset),
    .align_done     (align_done),
    .align_err      (align_err),
    .stb_pos_err    (stb_pos_err),
    .stb_coding_err (stb_coding_err)
    );

  assign rx_dout_valid = fifo_pop;   // Aligned words leave on each pop

endmodule

`default_nettype wire

// File: design/ca_rx_lane.sv
// Receive lane with strobe detection, deskew FIFO and strobe interval check
`timescale 1ns/100ps
`default_nettype none

`include "ca_align_macros.svh"

module ca_rx_lane
  (
  input  logic                     com_clk,
  input  logic                     rst_com_n,
  input  ca_align_pkg::lane_data_t din,
  input  ca_align_pkg::stb_cfg_t   stb_cfg,
  input  logic                     det_en,
  input  logic                     fifo_pop,
  input  logic                     soft_reset,
  output ca_align_pkg::lane_data_t dout,
  output ca_align_pkg::lane_stat_t stat
  );

  import ca_align_pkg::*;

  localparam int DEPTH    = 1 << `CA_FIFO_AW;
  localparam int EXT_BITS = `CA_SEL_WORDS * `CA_WORD_BITS;

  logic [EXT_BITS-1:0]      din_ext;
  logic [`CA_WORD_BITS-1:0] sel_word;
  logic                     stb_word;
  logic                     first_stb;
  logic                     push;
  logic                     do_pop;
  logic                     can_wr;
  logic [`CA_FIFO_AW:0]     wr_ptr;
  logic [`CA_FIFO_AW:0]     rd_ptr;
  logic                     full;
  logic                     empty;
  logic                     overflow;
  logic [`CA_INTV_BITS-1:0] intv_cnt;
  logic                     intv_err;
  lane_data_t               mem [DEPTH];

  //////////////////////////////////////////////////
  // Strobe detection

  // Words past the lane width read as zero
  assign din_ext = {{(EXT_BITS - `CA_LANE_BITS){1'b0}}, din};

  always_comb
  begin
    sel_word = din_ext[0 +: `CA_WORD_BITS];  // Word 0 if nothing selected
    for (int w = `CA_SEL_WORDS - 1; w >= 0; w--)
    begin
      if (stb_cfg.wd_sel[w])
        sel_word = din_ext[w * `CA_WORD_BITS +: `CA_WORD_BITS];
    end
  end

  assign stb_word = det_en & (|(sel_word & stb_cfg.bit_sel));

  //////////////////////////////////////////////////
  // Deskew FIFO

  // Write from the strobe word onward
  assign push   = (stb_word | first_stb) & ~soft_reset;
  assign empty  = (wr_ptr == rd_ptr);
  assign full   = (wr_ptr[`CA_FIFO_AW] != rd_ptr[`CA_FIFO_AW]) &&
                  (wr_ptr[`CA_FIFO_AW-1:0] == rd_ptr[`CA_FIFO_AW-1:0]);
  assign do_pop = fifo_pop & ~empty;
  assign can_wr = ~full | do_pop;   // A pop frees the slot this cycle

  always_ff @(posedge com_clk)
  begin
    if (push & can_wr)
      mem[wr_ptr[`CA_FIFO_AW-1:0]] <= din;
  end

  assign dout = mem[rd_ptr[`CA_FIFO_AW-1:0]];  // Head word shown before the pop

  always_ff @(posedge com_clk or negedge rst_com_n)
  begin
    if (!rst_com_n)
    begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      overflow  <= 1'b0;
      first_stb <= 1'b0;
    end
    else if (soft_reset)
    begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      overflow  <= 1'b0;
      first_stb <= 1'b0;
    end
    else
    begin
      if (push & can_wr)
        wr_ptr <= wr_ptr + 1'b1;
      if (do_pop)
        rd_ptr <= rd_ptr + 1'b1;
      overflow  <= push & ~can_wr;        // Word dropped
      first_stb <= first_stb | stb_word;
    end
  end

  //////////////////////////////////////////////////
  // Strobe interval check

  always_ff @(posedge com_clk or negedge rst_com_n)
  begin
    if (!rst_com_n)
    begin
      intv_cnt <= '0;
      intv_err <= 1'b0;
    end
    else if (soft_reset)
    begin
      intv_cnt <= '0;
      intv_err <= 1'b0;
    end
    else if (stb_word)
      intv_cnt <= stb_cfg.intv;
    else if (first_stb)
    begin
      if (intv_cnt == `CA_INTV_BITS'(1))
      begin
        intv_err <= 1'b1;              // Strobe missing
        intv_cnt <= stb_cfg.intv;
      end
      else
        intv_cnt <= intv_cnt - 1'b1;
    end
  end

  assign stat.first_stb = first_stb;
  assign stat.overflow  = overflow;
  assign stat.intv_err  = intv_err;
  assign stat.full      = full;
  assign stat.empty     = empty;

endmodule

`default_nettype wire

// File: files.f
+incdir+design
design/ca_align_pkg.sv
design/ca_rx_lane.sv
design/ca_align_ctrl.sv
design/ca_rx_align.sv
bench/ca_rx_align_props.sv
bench/ca_rx_align_tb.sv
